/* Makefile */
# Verilator build, run and lint for the spy port testbench

VERILATOR ?= verilator
TOP       ?= spy_port_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FILELIST)

# The run passes only when the testbench prints the pass line
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* dv/spy_port_tb.sv */
`timescale 1ns/10ps

`include "spy_defs.svh"

module spy_port_tb;

   import spy_bus_pkg::*;

   localparam int CLK_PERIOD      = 20;
   localparam int RESET_CYCLES    = 5;
   localparam int SEED            = 9032;
   localparam int NUM_READS       = 20 + 20 + 8 + 8 + 13 + 16; // Reads issued by tests 1 to 6
   localparam int CYCLES_PER_READ = 6;  // Issue, two pipeline stages, drain and spare
   localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_READS * CYCLES_PER_READ + 100;
   localparam int DRAIN_LIMIT     = 10;

   logic                   clk;
   logic                   reset;
   logic                   state_write;
   logic [`SPY_WORD_W-1:0] word_in [`SPY_NUM_LANES]; // A, M, MD, OB, VMA
   logic [48:0]            ir;
   logic [13:0]            pc;
   logic [13:0]            opc;
   logic [15:0]            scratch;
   logic [4:0]             disk_state;
   logic [11:0]            bd_state;
   logic                   waiting, boot, promdisable, stathalt, err, ssdone, srun;
   logic                   wmap, destspc, iwrited, imod, pdlwrite, spush;
   logic                   nop, vmaok, jcond, pcs1, pcs0;
   logic                   rd;
   spy_addr_t              addr;
   logic [`SPY_HALF_W-1:0] spy_data;
   logic                   spy_valid;

   logic [`SPY_WORD_W-1:0] snap_model [`SPY_NUM_LANES]; // Words as of the last state_write
   logic [`SPY_HALF_W-1:0] exp_q [$];
   logic [`SPY_HALF_W-1:0] exp_head; // Result due at the next rising edge
   int                     errors;   // Failed assertions on the result stream
   int                     misses;   // Failures found by the stimulus process
   int                     checks;

   spy_port spy_port_i (
      .a   (word_in[0]),
      .m   (word_in[1]),
      .md  (word_in[2]),
      .ob  (word_in[3]),
      .vma (word_in[4]),
      .*
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // A result comes back exactly two cycles after each read strobe
   assert property (@(posedge clk) disable iff (reset) spy_valid == $past(rd, 2))
      else begin
         errors++;
         $display("FAIL %0t: spy_valid does not follow rd by two cycles", $time);
      end

   assert property (@(posedge clk) disable iff (reset) spy_valid |-> spy_data == exp_head)
      else begin
         errors++;
         $display("FAIL %0t: spy_data %h, expected %h", $time, $sampled(spy_data),
                  $sampled(exp_head));
      end

   // The data bus holds its last result between reads
   assert property (@(posedge clk) disable iff (reset) !spy_valid |-> $stable(spy_data))
      else begin
         errors++;
         $display("FAIL %0t: spy_data changed to %h without spy_valid", $time,
                  $sampled(spy_data));
      end

   // Lines up the oldest prediction with the result now on spy_data
   always @(negedge clk) begin
      if (spy_valid && exp_q.size() != 0) begin
         exp_head = exp_q.pop_front();
         checks++;
      end
   end

   // Flag word 1 fills bits 15 to 8 and leaves the low byte zero
   function automatic logic [15:0] flag1_word();
      logic [15:0] f;
      f     = '0;
      f[15] = waiting;
      f[13] = boot;
      f[12] = promdisable;
      f[11] = stathalt;
      f[10] = err;
      f[9]  = ssdone;
      f[8]  = srun;
      return f;
   endfunction

   function automatic logic [15:0] flag2_word();
      logic [15:0] f;
      f     = '0;
      f[13] = wmap;
      f[12] = destspc;
      f[11] = iwrited;
      f[10] = imod;
      f[9]  = pdlwrite;
      f[8]  = spush;
      f[5]  = ir[48]; // Top IR bit rides in the decode word
      f[4]  = nop;
      f[3]  = vmaok;
      f[2]  = jcond;
      f[1]  = pcs1;
      f[0]  = pcs0;
      return f;
   endfunction

   function automatic logic [`SPY_HALF_W-1:0] predict(input spy_addr_t a);
      logic [`SPY_WORD_W-1:0] w;
      logic [`SPY_HALF_W-1:0] r;
      r = '1; // Anything unmapped reads as all ones
      if (a.misc_v.misc) begin
         if (!a.misc_v.rsvd) begin
            case (a.misc_v.sel)
               MISC_IRH:     r = ir[47:32];
               MISC_IRM:     r = ir[31:16];
               MISC_IRL:     r = ir[15:0];
               MISC_FLAG1:   r = flag1_word();
               MISC_FLAG2:   r = flag2_word();
               MISC_OPC:     r = {2'b00, opc};
               MISC_PC:      r = {2'b00, pc};
               MISC_SCRATCH: r = scratch;
               MISC_DISK:    r = {11'b0, disk_state};
               MISC_BD:      r = {4'b0, bd_state};
               default:      r = '1;
            endcase
         end
      end else if (a.lane_v.lane < `SPY_NUM_LANES) begin
         w = a.lane_v.last ? snap_model[a.lane_v.lane] : word_in[a.lane_v.lane];
         r = a.lane_v.half ? w[31:16] : w[15:0];
      end
      return r;
   endfunction

   task automatic randomize_words();
      foreach (word_in[i]) word_in[i] = $urandom;
   endtask

   task automatic randomize_cpu_state();
      ir         = {17'($urandom), $urandom};
      pc         = 14'($urandom);
      opc        = 14'($urandom);
      scratch    = 16'($urandom);
      disk_state = 5'($urandom);
      bd_state   = 12'($urandom);
      {waiting, boot, promdisable, stathalt, err, ssdone, srun} = 7'($urandom);
      {wmap, destspc, iwrited, imod, pdlwrite, spush} = 6'($urandom);
      {nop, vmaok, jcond, pcs1, pcs0} = 5'($urandom);
   endtask

   task automatic issue_read(input spy_addr_t a);
      @(negedge clk);
      rd   = 1'b1;
      addr = a;
      exp_q.push_back(predict(a)); // Inputs stay put until the burst drains
   endtask

   task automatic finish_reads();
      int waited;
      waited = 0;
      @(negedge clk);
      rd = 1'b0;
      while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      if (exp_q.size() != 0) begin
         misses++;
         $display("No spy_valid seen for %0d outstanding reads after %0d cycles",
                  exp_q.size(), waited);
         exp_q.delete();
      end
      @(negedge clk); // Last check fires at the rising edge in between
   endtask

   task automatic single_read(input spy_addr_t a);
      issue_read(a);
      finish_reads();
   endtask

   task automatic report_test(input int num, input string name, input int fails_before);
      $display("Test %0d %s: %s", num, name,
               (errors + misses == fails_before) ? "ok" : "errors found");
   endtask

   initial begin
      int fails_before;
      void'($urandom(SEED));
      reset       = 1'b1;
      state_write = 1'b0;
      rd          = 1'b0;
      addr        = '0;
      exp_head    = '1;
      errors      = 0;
      misses      = 0;
      checks      = 0;
      foreach (snap_model[i]) snap_model[i] = '0;
      randomize_words();
      randomize_cpu_state();
      repeat (RESET_CYCLES) @(negedge clk);
      reset = 1'b0;

      fails_before = errors + misses;
      repeat (3) @(negedge clk);
      assert (!spy_valid && spy_data == '1)
         else begin
            misses++;
            $display("FAIL %0t: after reset spy_valid %b spy_data %h", $time, spy_valid, spy_data);
         end
      for (int lane = 0; lane < `SPY_NUM_LANES; lane++) begin
         for (int k = 0; k < 4; k++) begin
            single_read({1'b0, 3'(lane), k[1], k[0]}); // Snapshots still hold zero
         end
      end
      report_test(1, "reset state and live reads", fails_before);

      fails_before = errors + misses;
      randomize_words();
      @(negedge clk);
      state_write = 1'b1;
      snap_model  = word_in; // Lanes capture at the coming rising edge
      @(negedge clk);
      state_write = 1'b0;
      randomize_words();
      for (int lane = 0; lane < `SPY_NUM_LANES; lane++) begin
         for (int k = 0; k < 4; k++) begin
            single_read({1'b0, 3'(lane), k[1], k[0]});
         end
      end
      report_test(2, "snapshot against live words", fails_before);

      fails_before = errors + misses;
      randomize_cpu_state();
      for (int sel = 0; sel < SPY_NUM_MISC; sel++) begin
         if (sel != MISC_FLAG1 && sel != MISC_FLAG2) begin
            single_read({2'b10, 4'(sel)});
         end
      end
      report_test(3, "miscellaneous words", fails_before);

      fails_before = errors + misses;
      repeat (4) begin
         randomize_cpu_state();
         single_read({2'b10, MISC_FLAG1});
         single_read({2'b10, MISC_FLAG2});
      end
      report_test(4, "status flag words", fails_before);

      fails_before = errors + misses;
      for (int lane = `SPY_NUM_LANES; lane < 8; lane++) begin
         single_read({1'b0, 3'(lane), 2'($urandom)});
      end
      for (int sel = SPY_NUM_MISC; sel < 16; sel++) begin
         single_read({2'b10, 4'(sel)});
      end
      for (int sel = 0; sel < SPY_NUM_MISC; sel += 3) begin
         single_read({2'b11, 4'(sel)}); // Reserved bit set on a mapped code
      end
      report_test(5, "unmapped addresses", fails_before);

      fails_before = errors + misses;
      for (int n = 0; n < 16; n++) begin
         issue_read(n[0] ? {2'b10, 4'($urandom)} : {1'b0, 5'($urandom)}); // One read per cycle
      end
      finish_reads();
      report_test(6, "back-to-back reads", fails_before);

      $display("Tests 6, checks %0d, errors %0d", checks, errors + misses);
      if (errors + misses == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Watchdog expired after %0d cycles with tests still running", WATCHDOG_CYCLES);
      $display("RESULT: FAIL");
      $finish;
   end

endmodule

/* include/spy_defs.svh */
`ifndef SPY_DEFS_SVH
`define SPY_DEFS_SVH

// Datapath capture lanes in order A, M, MD, OB, VMA
`define SPY_NUM_LANES 5

`define SPY_WORD_W 32 // One datapath word
`define SPY_HALF_W 16 // Spy data bus

// Returned for a read at an unmapped address
`define SPY_IDLE_VALUE 16'hffff

`endif

/* project.f */
+incdir+include
src/spy_bus_pkg.sv
src/cpu_state_pkg.sv
src/spy_addr_decode.sv
src/spy_reg_lane.sv
src/spy_read_mux.sv
src/spy_port.sv
dv/spy_port_tb.sv

/* src/cpu_state_pkg.sv */
package cpu_state_pkg;

   // Flag word 1 carries the run and halt status of the processor
   function automatic logic [15:0] pack_flag1(
      input logic waiting,
      input logic boot,
      input logic promdisable,
      input logic stathalt,
      input logic err,
      input logic ssdone,
      input logic srun
   );
      return {waiting, 1'b0, boot, promdisable, stathalt, err, ssdone, srun,
              8'b0};
   endfunction

   // Flag word 2 carries the microinstruction decode and branch status
   function automatic logic [15:0] pack_flag2(
      input logic wmap,
      input logic destspc,
      input logic iwrited,
      input logic imod,
      input logic pdlwrite,
      input logic spush,
      input logic ir48,
      input logic nop,
      input logic vmaok,
      input logic jcond,
      input logic pcs1,
      input logic pcs0
   );
      return {2'b0, wmap, destspc, iwrited, imod, pdlwrite, spush,
              2'b0, ir48, nop, vmaok, jcond, pcs1, pcs0};
   endfunction

endpackage

/* src/spy_addr_decode.sv */
`timescale 1ns/10ps

`include "spy_defs.svh"

module spy_addr_decode (
   input  logic                                 clk,
   input  logic                                 reset,
   input  logic                                 rd,
   input  spy_bus_pkg::spy_addr_t               addr,
   output logic [`SPY_NUM_LANES-1:0]            lane_sel,
   output logic                                 use_last,
   output logic                                 half_hi,
   output logic [spy_bus_pkg::SPY_NUM_MISC-1:0] misc_sel,
   output logic                                 rd_q
);

   import spy_bus_pkg::*;

   logic [`SPY_NUM_LANES-1:0] lane_sel_d;
   logic [SPY_NUM_MISC-1:0]   misc_sel_d;

   // Selects stay clear unless a read is strobed this cycle
   always_comb begin
      lane_sel_d = '0;
      misc_sel_d = '0;
      if (rd) begin
         if (addr.misc_v.misc) begin
            // Codes past the last mapped word and a set reserved bit miss
            if (!addr.misc_v.rsvd && addr.misc_v.sel < SPY_NUM_MISC) begin
               misc_sel_d[addr.misc_v.sel] = 1'b1;
            end
         end else if (addr.lane_v.lane < `SPY_NUM_LANES) begin
            lane_sel_d[addr.lane_v.lane] = 1'b1; // Lanes 5 to 7 miss
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         lane_sel <= '0;
         misc_sel <= '0;
         use_last <= 1'b0;
         half_hi  <= 1'b0;
         rd_q     <= 1'b0;
      end else begin
         lane_sel <= lane_sel_d;
         misc_sel <= misc_sel_d;
         use_last <= addr.lane_v.last; // Only looked at when a lane is selected
         half_hi  <= addr.lane_v.half;
         rd_q     <= rd;
      end
   end

endmodule

/* src/spy_bus_pkg.sv */
package spy_bus_pkg;

   // Number of miscellaneous selector codes that map to a word
   localparam int SPY_NUM_MISC = 10;

   // Miscellaneous selector codes
   localparam logic [3:0] MISC_IRH     = 4'd0; // IR bits 47 to 32
   localparam logic [3:0] MISC_IRM     = 4'd1; // IR bits 31 to 16
   localparam logic [3:0] MISC_IRL     = 4'd2; // IR bits 15 to 0
   localparam logic [3:0] MISC_FLAG1   = 4'd3;
   localparam logic [3:0] MISC_FLAG2   = 4'd4;
   localparam logic [3:0] MISC_OPC     = 4'd5;
   localparam logic [3:0] MISC_PC      = 4'd6;
   localparam logic [3:0] MISC_SCRATCH = 4'd7;
   localparam logic [3:0] MISC_DISK    = 4'd8;
   localparam logic [3:0] MISC_BD      = 4'd9;

   // The spy address is read in one of two ways, chosen by its top bit.
   // With misc at 0 it names a datapath lane, a live or captured copy
   // and a half. With misc at 1 it names one of the miscellaneous words.
   typedef union packed {
      struct packed {
         logic       misc; // Always 0 in this view
         logic [2:0] lane; // 0 A, 1 M, 2 MD, 3 OB, 4 VMA
         logic       last; // Snapshot when set, live word when clear
         logic       half; // Upper half when set
      } lane_v;
      struct packed {
         logic       misc; // Always 1 in this view
         logic       rsvd; // Must be zero for a mapped read
         logic [3:0] sel;  // Selector code
      } misc_v;
   } spy_addr_t;

endpackage

/* src/spy_port.sv */
`timescale 1ns/10ps

`include "spy_defs.svh"

module spy_port (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   state_write, // One-cycle strobe from the processor
   input  logic [`SPY_WORD_W-1:0] a,
   input  logic [`SPY_WORD_W-1:0] m,
   input  logic [`SPY_WORD_W-1:0] md,
   input  logic [`SPY_WORD_W-1:0] ob,
   input  logic [`SPY_WORD_W-1:0] vma,
   input  logic [48:0]            ir,
   input  logic [13:0]            pc,
   input  logic [13:0]            opc,
   input  logic [15:0]            scratch,
   input  logic [4:0]             disk_state,
   input  logic [11:0]            bd_state,
   input  logic                   waiting,
   input  logic                   boot,
   input  logic                   promdisable,
   input  logic                   stathalt,
   input  logic                   err,
   input  logic                   ssdone,
   input  logic                   srun,
   input  logic                   wmap,
   input  logic                   destspc,
   input  logic                   iwrited,
   input  logic                   imod,
   input  logic                   pdlwrite,
   input  logic                   spush,
   input  logic                   nop,
   input  logic                   vmaok,
   input  logic                   jcond,
   input  logic                   pcs1,
   input  logic                   pcs0,
   input  logic                   rd,          // One-cycle read strobe from the debugger
   input  spy_bus_pkg::spy_addr_t addr,
   output logic [`SPY_HALF_W-1:0] spy_data,
   output logic                   spy_valid    // Two cycles after rd
);

   import spy_bus_pkg::*;

   logic [`SPY_NUM_LANES-1:0]             lane_sel;
   logic                                  use_last;
   logic                                  half_hi;
   logic [SPY_NUM_MISC-1:0]               misc_sel;
   logic                                  rd_q;
   logic [`SPY_NUM_LANES*`SPY_WORD_W-1:0] lane_words;
   logic [`SPY_NUM_LANES*`SPY_HALF_W-1:0] lane_half;

   assign lane_words = {vma, ob, md, m, a}; // Lane 0 sits in the low word

   spy_addr_decode spy_addr_decode_i (
      .clk      (clk),
      .reset    (reset),
      .rd       (rd),
      .addr     (addr),
      .lane_sel (lane_sel),
      .use_last (use_last),
      .half_hi  (half_hi),
      .misc_sel (misc_sel),
      .rd_q     (rd_q)
   );

   for (genvar i = 0; i < `SPY_NUM_LANES; i++) begin : g_lane
      spy_reg_lane spy_reg_lane_i (
         .clk         (clk),
         .reset       (reset),
         .state_write (state_write),
         .word        (lane_words[i*`SPY_WORD_W +: `SPY_WORD_W]),
         .sel         (lane_sel[i]),
         .use_last    (use_last),
         .half_hi     (half_hi),
         .half        (lane_half[i*`SPY_HALF_W +: `SPY_HALF_W])
      );
   end

   spy_read_mux spy_read_mux_i (
      .clk         (clk),
      .reset       (reset),
      .rd_q        (rd_q),
      .lane_sel    (lane_sel),
      .lane_half   (lane_half),
      .misc_sel    (misc_sel),
      .ir          (ir),
      .pc          (pc),
      .opc         (opc),
      .scratch     (scratch),
      .disk_state  (disk_state),
      .bd_state    (bd_state),
      .waiting     (waiting),
      .boot        (boot),
      .promdisable (promdisable),
      .stathalt    (stathalt),
      .err         (err),
      .ssdone      (ssdone),
      .srun        (srun),
      .wmap        (wmap),
      .destspc     (destspc),
      .iwrited     (iwrited),
      .imod        (imod),
      .pdlwrite    (pdlwrite),
      .spush       (spush),
      .nop         (nop),
      .vmaok       (vmaok),
      .jcond       (jcond),
      .pcs1        (pcs1),
      .pcs0        (pcs0),
      .spy_data    (spy_data),
      .spy_valid   (spy_valid)
   );

endmodule

/* src/spy_read_mux.sv */
`timescale 1ns/10ps

`include "spy_defs.svh"

module spy_read_mux (
   input  logic                                   clk,
   input  logic                                   reset,
   input  logic                                   rd_q,
   input  logic [`SPY_NUM_LANES-1:0]              lane_sel,
   input  logic [`SPY_NUM_LANES*`SPY_HALF_W-1:0]  lane_half,
   input  logic [spy_bus_pkg::SPY_NUM_MISC-1:0]   misc_sel,
   input  logic [48:0]                            ir,
   input  logic [13:0]                            pc,
   input  logic [13:0]                            opc,
   input  logic [15:0]                            scratch,
   input  logic [4:0]                             disk_state,
   input  logic [11:0]                            bd_state,
   input  logic                                   waiting,
   input  logic                                   boot,
   input  logic                                   promdisable,
   input  logic                                   stathalt,
   input  logic                                   err,
   input  logic                                   ssdone,
   input  logic                                   srun,
   input  logic                                   wmap,
   input  logic                                   destspc,
   input  logic                                   iwrited,
   input  logic                                   imod,
   input  logic                                   pdlwrite,
   input  logic                                   spush,
   input  logic                                   nop,
   input  logic                                   vmaok,
   input  logic                                   jcond,
   input  logic                                   pcs1,
   input  logic                                   pcs0,
   output logic [`SPY_HALF_W-1:0]                 spy_data,
   output logic                                   spy_valid
);

   import spy_bus_pkg::*;
   import cpu_state_pkg::*;

   logic [`SPY_HALF_W-1:0] lane_word;
   logic [`SPY_HALF_W-1:0] misc_word;
   logic [`SPY_HALF_W-1:0] flag1;
   logic [`SPY_HALF_W-1:0] flag2;
   logic                   hit;

   assign flag1 = pack_flag1(waiting, boot, promdisable, stathalt, err, ssdone, srun);
   assign flag2 = pack_flag2(wmap, destspc, iwrited, imod, pdlwrite, spush,
                             ir[48], nop, vmaok, jcond, pcs1, pcs0);

   // Unselected lanes already drive zero
   always_comb begin
      lane_word = '0;
      for (int i = 0; i < `SPY_NUM_LANES; i++) begin
         lane_word |= lane_half[i*`SPY_HALF_W +: `SPY_HALF_W];
      end
   end

   // AND-OR select of the miscellaneous words, narrow ones zero-extended
   always_comb begin
      misc_word = '0;
      if (misc_sel[MISC_IRH])     misc_word |= ir[47:32];
      if (misc_sel[MISC_IRM])     misc_word |= ir[31:16];
      if (misc_sel[MISC_IRL])     misc_word |= ir[15:0];
      if (misc_sel[MISC_FLAG1])   misc_word |= flag1;
      if (misc_sel[MISC_FLAG2])   misc_word |= flag2;
      if (misc_sel[MISC_OPC])     misc_word |= {2'b00, opc};
      if (misc_sel[MISC_PC])      misc_word |= {2'b00, pc};
      if (misc_sel[MISC_SCRATCH]) misc_word |= scratch;
      if (misc_sel[MISC_DISK])    misc_word |= {11'b0, disk_state};
      if (misc_sel[MISC_BD])      misc_word |= {4'b0, bd_state};
   end

   assign hit = |lane_sel || |misc_sel;

   always_ff @(posedge clk) begin
      if (reset) begin
         spy_data  <= `SPY_IDLE_VALUE;
         spy_valid <= 1'b0;
      end else begin
         spy_valid <= rd_q;
         if (rd_q) begin
            spy_data <= hit ? (lane_word | misc_word) : `SPY_IDLE_VALUE; // Miss reads all ones
         end
      end
   end

endmodule

/* src/spy_reg_lane.sv */
`timescale 1ns/10ps

`include "spy_defs.svh"

module spy_reg_lane (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   state_write,
   input  logic [`SPY_WORD_W-1:0] word,
   input  logic                   sel,
   input  logic                   use_last,
   input  logic                   half_hi,
   output logic [`SPY_HALF_W-1:0] half
);

   logic [`SPY_WORD_W-1:0] snap; // Word as it stood at the last state write
   logic [`SPY_WORD_W-1:0] src;

   always_ff @(posedge clk) begin
      if (reset) begin
         snap <= '0;
      end else if (state_write) begin
         snap <= word;
      end
   end

   assign src = use_last ? snap : word;

   // An idle lane drives zero so the read mux can OR all lanes together
   always_comb begin
      if (!sel) begin
         half = '0;
      end else if (half_hi) begin
         half = src[`SPY_WORD_W-1:`SPY_HALF_W];
      end else begin
         half = src[`SPY_HALF_W-1:0];
      end
   end

endmodule
